// ==== filelist.f ====
mmu_pkg.sv
tlb_write_ctrl.sv
tlb_entry.sv
tlb_match_select.sv
mips_tlb_top.sv
mips_tlb_props.sv
tb_mips_tlb.sv

// ==== mips_tlb_props.sv ====
// Concurrent checks on the lookup response handshake and fault flags of the data-side MMU

`timescale 1ns/1ps

module mips_tlb_props (
    input logic            clk,
    input logic            arst_n_i,
    input logic            lookup_en_i,
    input mmu_pkg::vaddr_u lookup_vaddr_i,
    input logic            rsp_valid_o,
    input logic            rsp_refill_o,
    input logic            rsp_invalid_o,
    input logic            rsp_modified_o
);

    import mmu_pkg::*;

    logic [2:0] flags;
    logic       unmapped;

    assign flags    = {rsp_refill_o, rsp_invalid_o, rsp_modified_o};
    assign unmapped = (lookup_vaddr_i.segment.seg == SEG_KSEG0) ||
                      (lookup_vaddr_i.segment.seg == SEG_KSEG1);

    a_flags_onehot: assert property (@(posedge clk) disable iff (!arst_n_i)
        $onehot0(flags))
        else $error("More than one fault flag is high");

    a_rsp_one_cycle: assert property (@(posedge clk) disable iff (!arst_n_i)
        rsp_valid_o == $past(lookup_en_i))
        else $error("rsp_valid_o does not follow lookup_en_i by one cycle");

    a_flags_idle: assert property (@(posedge clk) disable iff (!arst_n_i)
        !rsp_valid_o |-> flags == 3'b000)
        else $error("Fault flag high without a response");

    // kseg0 and kseg1 bypass the TLB entirely
    a_unmapped_clean: assert property (@(posedge clk) disable iff (!arst_n_i)
        rsp_valid_o && $past(lookup_en_i && unmapped) |-> flags == 3'b000)
        else $error("Fault flag on a kseg0 or kseg1 lookup");

endmodule

bind mips_tlb_top mips_tlb_props u_props (
    .clk            ( clk            ),
    .arst_n_i       ( arst_n_i       ),
    .lookup_en_i    ( lookup_en_i    ),
    .lookup_vaddr_i ( lookup_vaddr_i ),
    .rsp_valid_o    ( rsp_valid_o    ),
    .rsp_refill_o   ( rsp_refill_o   ),
    .rsp_invalid_o  ( rsp_invalid_o  ),
    .rsp_modified_o ( rsp_modified_o )
);

// ==== mips_tlb_top.sv ====
// Data-side MMU top level with the write controller, the TLB entry array and the selector

`timescale 1ns/1ps

module mips_tlb_top (
    input  logic                           clk,
    input  logic                           arst_n_i,

    input  logic                           wr_en_i,
    input  logic                           wr_random_i,
    input  logic [mmu_pkg::TLB_IDX_W-1:0]  wr_index_i,
    input  logic [31:0]                    entry_hi_i,
    input  logic [31:0]                    entry_lo0_i,
    input  logic [31:0]                    entry_lo1_i,

    input  logic                           lookup_en_i,
    input  mmu_pkg::vaddr_u                lookup_vaddr_i,
    input  logic                           lookup_store_i,
    input  logic [mmu_pkg::ASID_W-1:0]     lookup_asid_i,

    output logic                           rsp_valid_o,
    output logic [31:0]                    rsp_paddr_o,
    output logic                           rsp_cached_o,
    output logic                           rsp_refill_o,
    output logic                           rsp_invalid_o,
    output logic                           rsp_modified_o
);

    import mmu_pkg::*;

    logic [TLB_ENTRIES-1:0]              slot_we;
    logic [TLB_ENTRIES-1:0]              hit;
    logic [TLB_ENTRIES-1:0][PFN_W-1:0]   pfn;
    logic [TLB_ENTRIES-1:0][CATTR_W-1:0] cattr;
    logic [TLB_ENTRIES-1:0]              dirty;
    logic [TLB_ENTRIES-1:0]              valid;

    tlb_write_ctrl u_write_ctrl (
        .clk         ( clk         ),
        .arst_n_i    ( arst_n_i    ),
        .wr_en_i     ( wr_en_i     ),
        .wr_random_i ( wr_random_i ),
        .wr_index_i  ( wr_index_i  ),
        .slot_we_o   ( slot_we     )
    );

    // ************************************************************************
    // Entry array sharing the write words and the lookup
    // ************************************************************************

    for (genvar i = 0; i < TLB_ENTRIES; i++) begin : g_entry
        tlb_entry u_entry (
            .clk            ( clk            ),
            .arst_n_i       ( arst_n_i       ),
            .we_i           ( slot_we[i]     ),
            .entry_hi_i     ( entry_hi_i     ),
            .entry_lo0_i    ( entry_lo0_i    ),
            .entry_lo1_i    ( entry_lo1_i    ),
            .lookup_vaddr_i ( lookup_vaddr_i ),
            .lookup_asid_i  ( lookup_asid_i  ),
            .hit_o          ( hit[i]         ),
            .pfn_o          ( pfn[i]         ),
            .cattr_o        ( cattr[i]       ),
            .dirty_o        ( dirty[i]       ),
            .valid_o        ( valid[i]       )
        );
    end

    tlb_match_select u_match_select (
        .clk            ( clk            ),
        .arst_n_i       ( arst_n_i       ),
        .lookup_en_i    ( lookup_en_i    ),
        .lookup_vaddr_i ( lookup_vaddr_i ),
        .lookup_store_i ( lookup_store_i ),
        .hit_i          ( hit            ),
        .pfn_i          ( pfn            ),
        .cattr_i        ( cattr          ),
        .dirty_i        ( dirty          ),
        .valid_i        ( valid          ),
        .rsp_valid_o    ( rsp_valid_o    ),
        .rsp_paddr_o    ( rsp_paddr_o    ),
        .rsp_cached_o   ( rsp_cached_o   ),
        .rsp_refill_o   ( rsp_refill_o   ),
        .rsp_invalid_o  ( rsp_invalid_o  ),
        .rsp_modified_o ( rsp_modified_o )
    );

endmodule

// ==== mmu_pkg.sv ====
// Shared sizes, EntryLo/EntryHi field positions and address views for the data-side MMU

package mmu_pkg;

    // ************************************************************************
    // Sizes and widths
    // ************************************************************************

    localparam int TLB_ENTRIES = 16;
    localparam int TLB_IDX_W   = 4;
    localparam int VPN2_W      = 19;
    localparam int PFN_W       = 20;
    localparam int ASID_W      = 8;
    localparam int PAGE_OFS_W  = 12;
    localparam int CATTR_W     = 3;

    // ************************************************************************
    // Field positions in the EntryLo and EntryHi words
    // ************************************************************************

    // EntryLo carries PFN in 25..6, C in 5..3, then D, V and G
    localparam int LO_PFN_LSB = 6;
    localparam int LO_C_LSB   = 3;
    localparam int LO_D_BIT   = 2;
    localparam int LO_V_BIT   = 1;
    localparam int LO_G_BIT   = 0;

    // EntryHi has VPN2 on top at the same place as in a virtual address
    localparam int HI_ASID_LSB = 0;

    // ************************************************************************
    // Segment and cache attribute codes
    // ************************************************************************

    localparam logic [2:0] SEG_KSEG0 = 3'b100;
    localparam logic [2:0] SEG_KSEG1 = 3'b101;

    localparam logic [CATTR_W-1:0] CACHE_ATTR_CACHED = 3'd3;

    // ************************************************************************
    // Virtual address, seen either by segment or by page
    // ************************************************************************

    typedef struct packed {
        logic [2:0]  seg;
        logic [28:0] seg_ofs;
    } vaddr_seg_t;

    typedef struct packed {
        logic [VPN2_W-1:0]     vpn2;
        logic                  odd;
        logic [PAGE_OFS_W-1:0] page_ofs;
    } vaddr_page_t;

    typedef union packed {
        vaddr_seg_t  segment;
        vaddr_page_t page;
    } vaddr_u;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the MMU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mips_tlb -f filelist.f -o sim_mips_tlb
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_mips_tlb 2>&1)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q '^Testbench passed$'; then
    echo "Result: pass"
    exit 0
else
    echo "Result: fail"
    exit 1
fi

// ==== tb_mips_tlb.sv ====
// Table-driven testbench for the data-side MMU covering TLB writes, translation and faults

`timescale 1ns/1ps

module tb_mips_tlb;

    import mmu_pkg::*;

    typedef struct {
        int                   test;
        bit                   is_write;
        logic                 random;
        logic [TLB_IDX_W-1:0] index;
        logic [31:0]          hi;
        logic [31:0]          lo0;
        logic [31:0]          lo1;
        logic [31:0]          vaddr;
        logic                 store;
        logic [ASID_W-1:0]    asid;
        logic [31:0]          paddr;
        logic                 cached;
        logic [2:0]           flags;
    } row_t;

    logic                 clk;
    logic                 arst_n;
    logic                 wr_en;
    logic                 wr_random;
    logic [TLB_IDX_W-1:0] wr_index;
    logic [31:0]          entry_hi;
    logic [31:0]          entry_lo0;
    logic [31:0]          entry_lo1;
    logic                 lookup_en;
    vaddr_u               lookup_vaddr;
    logic                 lookup_store;
    logic [ASID_W-1:0]    lookup_asid;
    logic                 rsp_valid;
    logic [31:0]          rsp_paddr;
    logic                 rsp_cached;
    logic                 rsp_refill;
    logic                 rsp_invalid;
    logic                 rsp_modified;

    row_t  rows[$];
    string test_name[$];
    int    test_errors[$];
    int    errors      = 0;
    int    checks      = 0;
    int    cycle_count = 0;
    int    cycle_limit = 0;

    mips_tlb_top dut (
        .clk            ( clk          ),
        .arst_n_i       ( arst_n       ),
        .wr_en_i        ( wr_en        ),
        .wr_random_i    ( wr_random    ),
        .wr_index_i     ( wr_index     ),
        .entry_hi_i     ( entry_hi     ),
        .entry_lo0_i    ( entry_lo0    ),
        .entry_lo1_i    ( entry_lo1    ),
        .lookup_en_i    ( lookup_en    ),
        .lookup_vaddr_i ( lookup_vaddr ),
        .lookup_store_i ( lookup_store ),
        .lookup_asid_i  ( lookup_asid  ),
        .rsp_valid_o    ( rsp_valid    ),
        .rsp_paddr_o    ( rsp_paddr    ),
        .rsp_cached_o   ( rsp_cached   ),
        .rsp_refill_o   ( rsp_refill   ),
        .rsp_invalid_o  ( rsp_invalid  ),
        .rsp_modified_o ( rsp_modified )
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Testbench failed");
            $finish;
        end
    end

    // EntryHi carries VPN2 in 31..13 and the ASID at the bottom
    function automatic logic [31:0] make_hi(input logic [VPN2_W-1:0] vpn2,
                                            input logic [ASID_W-1:0] asid);
        make_hi = {vpn2, 13'b0} | (32'(asid) << HI_ASID_LSB);
    endfunction

    // The dvg argument holds D, V and G from left to right
    function automatic logic [31:0] make_lo(input logic [PFN_W-1:0] pfn,
                                            input logic [2:0] c, input logic [2:0] dvg);
        make_lo = (32'(pfn) << LO_PFN_LSB) | (32'(c) << LO_C_LSB) | (32'(dvg[2]) << LO_D_BIT)
                | (32'(dvg[1]) << LO_V_BIT) | (32'(dvg[0]) << LO_G_BIT);
    endfunction

    task automatic start_test(input string name);
        test_name.push_back(name);
        test_errors.push_back(0);
    endtask

    task automatic add_write(input logic random, input logic [TLB_IDX_W-1:0] index,
                             input logic [31:0] hi, input logic [31:0] lo0,
                             input logic [31:0] lo1);
        row_t row;
        row.test     = test_name.size() - 1;
        row.is_write = 1'b1;
        row.random   = random;
        row.index    = index;
        row.hi       = hi;
        row.lo0      = lo0;
        row.lo1      = lo1;
        rows.push_back(row);
    endtask

    // Flags are given as {refill, invalid, modified}
    task automatic add_lookup(input logic [31:0] vaddr, input logic store,
                              input logic [ASID_W-1:0] asid, input logic [31:0] paddr,
                              input logic cached, input logic [2:0] flags);
        row_t row;
        row.test     = test_name.size() - 1;
        row.is_write = 1'b0;
        row.vaddr    = vaddr;
        row.store    = store;
        row.asid     = asid;
        row.paddr    = paddr;
        row.cached   = cached;
        row.flags    = flags;
        rows.push_back(row);
    endtask

    task automatic build_table();
        start_test("reset state and unmapped segments");
        add_lookup(32'h0040_1234, 1'b0, 8'h01, 32'h0000_0000, 1'b0, 3'b100);
        add_lookup(32'h8012_3456, 1'b0, 8'h01, 32'h0012_3456, 1'b1, 3'b000);
        add_lookup(32'hA012_3456, 1'b0, 8'h01, 32'h0012_3456, 1'b0, 3'b000);
        start_test("indexed write and even/odd translation");
        add_write(1'b0, 4'd3, make_hi(19'h00200, 8'h01),
                  make_lo(20'h12345, 3'd3, 3'b110), make_lo(20'h0ABCD, 3'd2, 3'b110));
        add_lookup(32'h0040_0ABC, 1'b0, 8'h01, 32'h1234_5ABC, 1'b1, 3'b000);
        add_lookup(32'h0040_1FF0, 1'b0, 8'h01, 32'h0ABC_DFF0, 1'b0, 3'b000);
        add_lookup(32'h0040_0ABC, 1'b1, 8'h01, 32'h1234_5ABC, 1'b1, 3'b000);
        start_test("invalid and modified faults");
        add_write(1'b0, 4'd5, make_hi(19'h00300, 8'h01),
                  make_lo(20'h00777, 3'd3, 3'b000), make_lo(20'h00888, 3'd3, 3'b010));
        add_lookup(32'h0060_0010, 1'b0, 8'h01, 32'h0000_0000, 1'b0, 3'b010);
        add_lookup(32'h0060_1020, 1'b1, 8'h01, 32'h0000_0000, 1'b0, 3'b001);
        add_lookup(32'h0060_1020, 1'b0, 8'h01, 32'h0088_8020, 1'b1, 3'b000);
        start_test("ASID match and global pages");
        add_lookup(32'h0040_0ABC, 1'b0, 8'h02, 32'h0000_0000, 1'b0, 3'b100);
        add_write(1'b0, 4'd7, make_hi(19'h00400, 8'h09),
                  make_lo(20'h01111, 3'd3, 3'b111), make_lo(20'h02222, 3'd3, 3'b111));
        add_lookup(32'h0080_0044, 1'b0, 8'h02, 32'h0111_1044, 1'b1, 3'b000);
        add_write(1'b0, 4'd8, make_hi(19'h00500, 8'h09),
                  make_lo(20'h03333, 3'd3, 3'b111), make_lo(20'h04444, 3'd3, 3'b110));
        add_lookup(32'h00A0_0044, 1'b0, 8'h02, 32'h0000_0000, 1'b0, 3'b100);
        add_lookup(32'h00A0_1044, 1'b0, 8'h09, 32'h0444_4044, 1'b1, 3'b000);
        start_test("random replacement slots");
        add_write(1'b1, 4'd0, make_hi(19'h00600, 8'h01),
                  make_lo(20'h05555, 3'd3, 3'b110), make_lo(20'h05556, 3'd3, 3'b110));
        add_write(1'b1, 4'd0, make_hi(19'h00700, 8'h01),
                  make_lo(20'h06666, 3'd3, 3'b110), make_lo(20'h06667, 3'd3, 3'b110));
        add_lookup(32'h00C0_0008, 1'b0, 8'h01, 32'h0555_5008, 1'b1, 3'b000);
        add_lookup(32'h00E0_1008, 1'b0, 8'h01, 32'h0666_7008, 1'b1, 3'b000);
        add_write(1'b0, 4'd15, make_hi(19'h00800, 8'h01),
                  make_lo(20'h07777, 3'd3, 3'b110), make_lo(20'h07778, 3'd3, 3'b110));
        add_lookup(32'h00C0_0008, 1'b0, 8'h01, 32'h0000_0000, 1'b0, 3'b100);
        add_lookup(32'h00E0_1008, 1'b0, 8'h01, 32'h0666_7008, 1'b1, 3'b000);
        add_lookup(32'h0100_0008, 1'b0, 8'h01, 32'h0777_7008, 1'b1, 3'b000);
        add_write(1'b0, 4'd14, make_hi(19'h00900, 8'h01),
                  make_lo(20'h08888, 3'd3, 3'b110), make_lo(20'h08889, 3'd3, 3'b110));
        add_lookup(32'h00E0_1008, 1'b0, 8'h01, 32'h0000_0000, 1'b0, 3'b100);
        start_test("back-to-back lookups");
        add_lookup(32'h0040_0ABC, 1'b0, 8'h01, 32'h1234_5ABC, 1'b1, 3'b000);
        add_lookup(32'h8000_0100, 1'b0, 8'h01, 32'h0000_0100, 1'b1, 3'b000);
        add_lookup(32'h0060_0010, 1'b0, 8'h01, 32'h0000_0000, 1'b0, 3'b010);
        add_lookup(32'hA000_0200, 1'b1, 8'h01, 32'h0000_0200, 1'b0, 3'b000);
        add_lookup(32'h0080_1004, 1'b0, 8'h03, 32'h0222_2004, 1'b1, 3'b000);
    endtask

    task automatic note_error(input int r, input string msg);
        errors++;
        test_errors[rows[r].test]++;
        $display("[FAIL] %0d ns: row %0d %s", $time, r, msg);
    endtask

    task automatic check_response(input bit pending, input int r);
        if (!pending) begin
            if (rsp_valid !== 1'b0) begin
                note_error(r, "rsp_valid_o high with no lookup one cycle earlier");
            end
        end else begin
            checks++;
            if (rsp_valid !== 1'b1) begin
                note_error(r, "rsp_valid_o low one cycle after the lookup");
            end else if ({rsp_refill, rsp_invalid, rsp_modified} !== rows[r].flags) begin
                note_error(r, $sformatf("flags %b, expected %b",
                           {rsp_refill, rsp_invalid, rsp_modified}, rows[r].flags));
            end else if (rows[r].flags == 3'b000 && rsp_paddr !== rows[r].paddr) begin
                note_error(r, $sformatf("paddr %h, expected %h", rsp_paddr, rows[r].paddr));
            end else if (rows[r].flags == 3'b000 && rsp_cached !== rows[r].cached) begin
                note_error(r, $sformatf("cached %b, expected %b", rsp_cached, rows[r].cached));
            end
        end
    endtask

    task automatic report_test(input int t);
        if (test_errors[t] == 0) begin
            $display("Test %0d %s: ok", t + 1, test_name[t]);
        end else begin
            $display("Test %0d %s: %0d errors", t + 1, test_name[t], test_errors[t]);
        end
    endtask

    task automatic drive_idle();
        wr_en        = 1'b0;
        wr_random    = 1'b0;
        wr_index     = '0;
        entry_hi     = '0;
        entry_lo0    = '0;
        entry_lo1    = '0;
        lookup_en    = 1'b0;
        lookup_vaddr = '0;
        lookup_store = 1'b0;
        lookup_asid  = '0;
    endtask

    task automatic apply_row(input int r);
        drive_idle();
        if (rows[r].is_write) begin
            wr_en     = 1'b1;
            wr_random = rows[r].random;
            wr_index  = rows[r].index;
            entry_hi  = rows[r].hi;
            entry_lo0 = rows[r].lo0;
            entry_lo1 = rows[r].lo1;
        end else begin
            lookup_en    = 1'b1;
            lookup_vaddr = rows[r].vaddr;
            lookup_store = rows[r].store;
            lookup_asid  = rows[r].asid;
        end
    endtask

    initial begin
        bit pending;
        int pend_row;

        arst_n = 1'b0;
        drive_idle();
        build_table();
        cycle_limit = 4 * rows.size() + 50;
        pending  = 1'b0;
        pend_row = 0;

        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;

        // Each row takes one cycle and its response is checked at the next edge
        for (int r = 0; r < rows.size(); r++) begin
            @(posedge clk);
            #1;
            check_response(pending, pend_row);
            if (r > 0 && rows[r].test != rows[r - 1].test) begin
                report_test(rows[r - 1].test);
            end
            apply_row(r);
            pending  = !rows[r].is_write;
            pend_row = r;
        end
        @(posedge clk);
        #1;
        check_response(pending, pend_row);
        drive_idle();
        report_test(rows[rows.size() - 1].test);

        $display("Lookups checked %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== tlb_entry.sv ====
// Single TLB entry holding an even/odd page pair and matching a lookup against it

`timescale 1ns/1ps

module tlb_entry (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  logic                          we_i,
    input  logic [31:0]                   entry_hi_i,
    input  logic [31:0]                   entry_lo0_i,
    input  logic [31:0]                   entry_lo1_i,
    input  mmu_pkg::vaddr_u               lookup_vaddr_i,
    input  logic [mmu_pkg::ASID_W-1:0]    lookup_asid_i,
    output logic                          hit_o,
    output logic [mmu_pkg::PFN_W-1:0]     pfn_o,
    output logic [mmu_pkg::CATTR_W-1:0]   cattr_o,
    output logic                          dirty_o,
    output logic                          valid_o
);

    import mmu_pkg::*;

    vaddr_u              hi_view;

    logic                present_q;
    logic [VPN2_W-1:0]   vpn2_q;
    logic [ASID_W-1:0]   asid_q;
    logic                global_q;

    // Index 0 is the even page, index 1 the odd page
    logic [1:0][PFN_W-1:0]   pfn_q;
    logic [1:0][CATTR_W-1:0] cattr_q;
    logic [1:0]              dirty_q;
    logic [1:0]              valid_q;

    logic                vpn2_match;
    logic                asid_match;

    // EntryHi keeps VPN2 at the same bits as a virtual address
    assign hi_view = entry_hi_i;

    // ************************************************************************
    // Storage
    // ************************************************************************

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            present_q <= 1'b0;
        end else if (we_i) begin
            present_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (we_i) begin
            vpn2_q     <= hi_view.page.vpn2;
            asid_q     <= entry_hi_i[HI_ASID_LSB +: ASID_W];
            global_q   <= entry_lo0_i[LO_G_BIT] & entry_lo1_i[LO_G_BIT];
            pfn_q[0]   <= entry_lo0_i[LO_PFN_LSB +: PFN_W];
            pfn_q[1]   <= entry_lo1_i[LO_PFN_LSB +: PFN_W];
            cattr_q[0] <= entry_lo0_i[LO_C_LSB +: CATTR_W];
            cattr_q[1] <= entry_lo1_i[LO_C_LSB +: CATTR_W];
            dirty_q    <= {entry_lo1_i[LO_D_BIT], entry_lo0_i[LO_D_BIT]};
            valid_q    <= {entry_lo1_i[LO_V_BIT], entry_lo0_i[LO_V_BIT]};
        end
    end

    // ************************************************************************
    // Match and half select
    // ************************************************************************

    assign vpn2_match = present_q && (vpn2_q == lookup_vaddr_i.page.vpn2);
    assign asid_match = global_q || (asid_q == lookup_asid_i);
    assign hit_o      = vpn2_match && asid_match;

    assign pfn_o   = pfn_q[lookup_vaddr_i.page.odd];
    assign cattr_o = cattr_q[lookup_vaddr_i.page.odd];
    assign dirty_o = dirty_q[lookup_vaddr_i.page.odd];
    assign valid_o = valid_q[lookup_vaddr_i.page.odd];

endmodule

// ==== tlb_match_select.sv ====
// Hit priority select, segment mapping and the registered translation result

`timescale 1ns/1ps

module tlb_match_select (
    input  logic                                                 clk,
    input  logic                                                 arst_n_i,
    input  logic                                                 lookup_en_i,
    input  mmu_pkg::vaddr_u                                      lookup_vaddr_i,
    input  logic                                                 lookup_store_i,
    input  logic [mmu_pkg::TLB_ENTRIES-1:0]                      hit_i,
    input  logic [mmu_pkg::TLB_ENTRIES-1:0][mmu_pkg::PFN_W-1:0]  pfn_i,
    input  logic [mmu_pkg::TLB_ENTRIES-1:0][mmu_pkg::CATTR_W-1:0] cattr_i,
    input  logic [mmu_pkg::TLB_ENTRIES-1:0]                      dirty_i,
    input  logic [mmu_pkg::TLB_ENTRIES-1:0]                      valid_i,
    output logic                                                 rsp_valid_o,
    output logic [31:0]                                          rsp_paddr_o,
    output logic                                                 rsp_cached_o,
    output logic                                                 rsp_refill_o,
    output logic                                                 rsp_invalid_o,
    output logic                                                 rsp_modified_o
);

    import mmu_pkg::*;

    logic               any_hit;
    logic [PFN_W-1:0]   win_pfn;
    logic [CATTR_W-1:0] win_cattr;
    logic               win_dirty;
    logic               win_valid;

    logic               unmapped;
    logic [31:0]        paddr_nxt;
    logic               cached_nxt;
    logic               refill_nxt;
    logic               invalid_nxt;
    logic               modified_nxt;

    // ************************************************************************
    // Winner select
    // ************************************************************************

    // Scanning downwards lets the lowest hitting index win
    always_comb begin
        win_pfn   = '0;
        win_cattr = '0;
        win_dirty = 1'b0;
        win_valid = 1'b0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (hit_i[i]) begin
                win_pfn   = pfn_i[i];
                win_cattr = cattr_i[i];
                win_dirty = dirty_i[i];
                win_valid = valid_i[i];
            end
        end
    end

    assign any_hit = |hit_i;

    // ************************************************************************
    // Segment rules
    // ************************************************************************

    assign unmapped = (lookup_vaddr_i.segment.seg == SEG_KSEG0) ||
                      (lookup_vaddr_i.segment.seg == SEG_KSEG1);

    always_comb begin
        if (unmapped) begin
            // kseg0 and kseg1 both drop the top three address bits
            paddr_nxt    = {3'b000, lookup_vaddr_i.segment.seg_ofs};
            cached_nxt   = (lookup_vaddr_i.segment.seg == SEG_KSEG0);
            refill_nxt   = 1'b0;
            invalid_nxt  = 1'b0;
            modified_nxt = 1'b0;
        end else begin
            paddr_nxt    = {win_pfn, lookup_vaddr_i.page.page_ofs};
            cached_nxt   = (win_cattr == CACHE_ATTR_CACHED);
            refill_nxt   = !any_hit;
            invalid_nxt  = any_hit && !win_valid;
            modified_nxt = any_hit && win_valid && lookup_store_i && !win_dirty;
        end
    end

    // ************************************************************************
    // Response register
    // ************************************************************************

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rsp_valid_o    <= 1'b0;
            rsp_refill_o   <= 1'b0;
            rsp_invalid_o  <= 1'b0;
            rsp_modified_o <= 1'b0;
        end else begin
            rsp_valid_o    <= lookup_en_i;
            rsp_refill_o   <= lookup_en_i & refill_nxt;
            rsp_invalid_o  <= lookup_en_i & invalid_nxt;
            rsp_modified_o <= lookup_en_i & modified_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_en_i) begin
            rsp_paddr_o  <= paddr_nxt;
            rsp_cached_o <= cached_nxt;
        end
    end

endmodule

// ==== tlb_write_ctrl.sv ====
// Write controller that picks the TLB slot for indexed or random writes

`timescale 1ns/1ps

module tlb_write_ctrl (
    input  logic                             clk,
    input  logic                             arst_n_i,
    input  logic                             wr_en_i,
    input  logic                             wr_random_i,
    input  logic [mmu_pkg::TLB_IDX_W-1:0]    wr_index_i,
    output logic [mmu_pkg::TLB_ENTRIES-1:0]  slot_we_o
);

    import mmu_pkg::*;

    logic [TLB_IDX_W-1:0] random_q;
    logic [TLB_IDX_W-1:0] random_nxt;
    logic [TLB_IDX_W-1:0] target_slot;
    logic                 random_wr;

    // ************************************************************************
    // Replacement counter
    // ************************************************************************

    assign random_wr = wr_en_i & wr_random_i;

    // Counts down and wraps back to the top slot
    always_comb begin
        if (random_q == '0) begin
            random_nxt = TLB_IDX_W'(TLB_ENTRIES - 1);
        end else begin
            random_nxt = random_q - 1'b1;
        end
    end

    // Indexed writes leave the counter where it is
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            random_q <= TLB_IDX_W'(TLB_ENTRIES - 1);
        end else if (random_wr) begin
            random_q <= random_nxt;
        end
    end

    // ************************************************************************
    // Slot decode
    // ************************************************************************

    assign target_slot = wr_random_i ? random_q : wr_index_i;

    // The entry stores at the same edge that samples wr_en_i
    always_comb begin
        slot_we_o = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (wr_en_i && (target_slot == TLB_IDX_W'(i))) begin
                slot_we_o[i] = 1'b1;
            end
        end
    end

endmodule
